//--- rtl/gpu_consts.svh
`ifndef GPU_CONSTS_SVH
`define GPU_CONSTS_SVH

// shader core count.
`define NUM_CORES   2

// tile and frame geometry.
`define TILE_PIXELS 4
`define FB_COLS     8
`define FB_LINES    4
`define FB_PIXELS   (`FB_COLS * `FB_LINES)
`define NUM_TILES   (`FB_PIXELS / `TILE_PIXELS)

// raster blanking, in clk cycles.
`define H_BLANK     2
`define V_BLANK     10

// data widths.
`define PIX_W       5
`define COLOR_W     8
`define TILE_W      3

`endif

//--- rtl/gpu_pkg.sv
`default_nettype none

`include "gpu_consts.svh"

package gpu_pkg;

    typedef logic [`PIX_W-1:0]     pix_addr_t;   // framebuffer address.
    typedef logic [`COLOR_W-1:0]   color_t;      // pixel color or kernel parameter.
    typedef logic [`TILE_W-1:0]    tile_idx_t;
    typedef logic [`NUM_CORES-1:0] core_mask_t;  // one bit per shader core.

    typedef enum logic [1:0] {
        SCHED_IDLE, SCHED_DISPATCH, SCHED_DRAIN, SCHED_DISPLAY
    } sched_state_t;

    typedef enum logic [1:0] {
        CORE_IDLE, CORE_COMPUTE, CORE_WRITE
    } core_state_t;

    typedef enum logic [1:0] {
        SCAN_OFF, SCAN_ACTIVE, SCAN_HBLANK, SCAN_VBLANK
    } scan_state_t;

endpackage

`default_nettype wire

//--- rtl/task_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpu_consts.svh"

module task_scheduler
    import gpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       launch,
    input  color_t     kernel_mul,
    input  color_t     kernel_add,
    input  core_mask_t core_ready,
    input  logic       scan_done,
    output core_mask_t core_start,
    output pix_addr_t  tile_base,
    output color_t     mul,
    output color_t     add,
    output logic       scan_start,
    output logic       frame_done,
    output logic       busy
);

    sched_state_t state;
    tile_idx_t    tile_cnt;
    core_mask_t   pick;
    logic         all_ready;
    logic         accept;

    // pick is one-hot on the lowest-numbered ready core, or zero.
    always_comb begin
        pick = '0;
        for (int i = `NUM_CORES - 1; i >= 0; i--) begin
            if (core_ready[i]) begin
                pick = core_mask_t'(1) << i;
            end
        end
    end

    assign all_ready  = &core_ready;
    assign accept     = (state == SCHED_IDLE) && launch;  // a launch while busy is dropped.

    assign core_start = (state == SCHED_DISPATCH) ? pick : '0;
    assign tile_base  = pix_addr_t'(tile_cnt * `TILE_PIXELS);

    assign frame_done = (state == SCHED_DRAIN) && all_ready;
    assign scan_start = frame_done;  // the raster begins right behind the last write.
    assign busy       = (state != SCHED_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SCHED_IDLE;
            tile_cnt <= '0;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (accept) begin
                        tile_cnt <= '0;
                        state    <= SCHED_DISPATCH;
                    end
                end
                SCHED_DISPATCH: begin
                    if (|pick) begin
                        tile_cnt <= tile_cnt + 1'b1;
                        if (tile_cnt == tile_idx_t'(`NUM_TILES - 1)) begin
                            state <= SCHED_DRAIN;  // all tiles issued, wait for the cores.
                        end
                    end
                end
                SCHED_DRAIN: begin
                    if (all_ready) begin
                        state <= SCHED_DISPLAY;
                    end
                end
                SCHED_DISPLAY: begin
                    if (scan_done) begin
                        state <= SCHED_IDLE;
                    end
                end
                default: begin
                    state <= SCHED_IDLE;
                end
            endcase
        end
    end

    // Kernel parameters stay fixed for the whole frame.
    always_ff @(posedge clk) begin
        if (accept) begin
            mul <= kernel_mul;
            add <= kernel_add;
        end
    end

endmodule

`default_nettype wire

//--- rtl/shader_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpu_consts.svh"

module shader_core
    import gpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  pix_addr_t tile_base,
    input  color_t    mul,
    input  color_t    add,
    input  logic      mem_ack,
    output logic      ready,
    output logic      mem_req,
    output pix_addr_t mem_addr,
    output color_t    mem_data
);

    localparam int CNT_W = $clog2(`TILE_PIXELS);

    core_state_t      state;
    logic [CNT_W-1:0] pix_cnt;
    pix_addr_t        pix_addr;
    color_t           color;
    logic             last_pix;
    logic             done_wr;

    // color of the current pixel, wrapping modulo 256.
    assign color    = color_t'(pix_addr) * mul + add;

    assign last_pix = (pix_cnt == CNT_W'(`TILE_PIXELS - 1));
    assign done_wr  = (state == CORE_WRITE) && mem_ack;

    assign ready    = (state == CORE_IDLE);
    assign mem_req  = (state == CORE_WRITE);  // held until the arbiter acks it.
    assign mem_addr = pix_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= CORE_IDLE;
            pix_cnt <= '0;
        end else begin
            case (state)
                CORE_IDLE: begin
                    if (start) begin
                        pix_cnt <= '0;
                        state   <= CORE_COMPUTE;
                    end
                end
                CORE_COMPUTE: begin
                    state <= CORE_WRITE;
                end
                CORE_WRITE: begin
                    if (mem_ack) begin
                        if (last_pix) begin
                            state <= CORE_IDLE;  // tile finished, ready rises next cycle.
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                            state   <= CORE_COMPUTE;
                        end
                    end
                end
                default: begin
                    state <= CORE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CORE_IDLE && start) begin
            pix_addr <= tile_base;
        end else if (done_wr) begin
            pix_addr <= pix_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == CORE_COMPUTE) begin
            mem_data <= color;
        end
    end

endmodule

`default_nettype wire

//--- rtl/shared_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpu_consts.svh"

module shared_mem
    import gpu_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  core_mask_t                     req,
    input  logic [`NUM_CORES*`PIX_W-1:0]   wr_addr,
    input  logic [`NUM_CORES*`COLOR_W-1:0] wr_data,
    input  pix_addr_t                      rd_addr,
    output core_mask_t                     ack,
    output color_t                         rd_data
);

    localparam int PTR_W = ($clog2(`NUM_CORES) > 0) ? $clog2(`NUM_CORES) : 1;

    color_t           mem [`FB_PIXELS];
    logic [PTR_W-1:0] last_grant;
    logic [PTR_W-1:0] grant_idx;
    pix_addr_t        grant_addr;
    color_t           grant_data;

    // Round-robin search that starts at the core after the last grant.
    always_comb begin : arbiter
        int   idx;
        logic found;
        idx       = 0;
        found     = 1'b0;
        ack       = '0;
        grant_idx = last_grant;
        for (int k = 1; k <= `NUM_CORES; k++) begin
            idx = (int'(last_grant) + k) % `NUM_CORES;
            if (!found && req[idx]) begin
                found     = 1'b1;
                ack[idx]  = 1'b1;
                grant_idx = PTR_W'(idx);
            end
        end
    end

    assign grant_addr = wr_addr[grant_idx*`PIX_W +: `PIX_W];
    assign grant_data = wr_data[grant_idx*`COLOR_W +: `COLOR_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= PTR_W'(`NUM_CORES - 1);  // core 0 wins the first contest.
        end else if (|ack) begin
            last_grant <= grant_idx;
        end
    end

    // the write commits at the edge that closes the ack cycle.
    always_ff @(posedge clk) begin
        if (|ack) begin
            mem[grant_addr] <= grant_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];  // scanout data arrives one cycle after the address.
    end

endmodule

`default_nettype wire

//--- rtl/scanout.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpu_consts.svh"

module scanout
    import gpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  color_t    rd_data,
    output pix_addr_t rd_addr,
    output color_t    pixel,
    output logic      blank_n,
    output logic      h_sync,
    output logic      v_sync,
    output logic      done
);

    localparam int CNT_W  = $clog2((`V_BLANK > `FB_COLS) ? `V_BLANK : `FB_COLS);
    localparam int LINE_W = $clog2(`FB_LINES);

    scan_state_t       state;
    logic [CNT_W-1:0]  cnt;
    logic [LINE_W-1:0] line;
    pix_addr_t         addr;
    logic              line_end;
    logic              hblank_end;
    logic              last_line;
    logic              issue;

    assign line_end   = (state == SCAN_ACTIVE) && (cnt == CNT_W'(`FB_COLS - 1));
    assign hblank_end = (state == SCAN_HBLANK) && (cnt == CNT_W'(`H_BLANK - 1));
    assign last_line  = (line == LINE_W'(`FB_LINES - 1));

    // A read goes out whenever the next cycle is an active one.
    assign issue = (state == SCAN_OFF && start) || (state == SCAN_ACTIVE && !line_end)
                || (hblank_end && !last_line);

    assign rd_addr = addr;
    assign pixel   = rd_data;
    assign blank_n = (state == SCAN_ACTIVE);
    assign h_sync  = (state == SCAN_HBLANK);
    assign v_sync  = (state == SCAN_VBLANK);
    assign done    = (state == SCAN_VBLANK) && (cnt == CNT_W'(`V_BLANK - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCAN_OFF;
            cnt   <= '0;
            line  <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                SCAN_OFF: begin
                    cnt  <= '0;
                    line <= '0;
                    if (start) begin
                        state <= SCAN_ACTIVE;
                    end
                end
                SCAN_ACTIVE: begin
                    if (line_end) begin
                        cnt   <= '0;
                        state <= SCAN_HBLANK;
                    end
                end
                SCAN_HBLANK: begin
                    if (hblank_end) begin
                        cnt   <= '0;
                        line  <= line + 1'b1;
                        state <= last_line ? SCAN_VBLANK : SCAN_ACTIVE;
                    end
                end
                SCAN_VBLANK: begin
                    if (done) begin
                        state <= SCAN_OFF;  // one frame per kernel.
                    end
                end
                default: begin
                    state <= SCAN_OFF;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr <= '0;
        end else if (issue) begin
            addr <= addr + 1'b1;
        end else if (state == SCAN_OFF) begin
            addr <= '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/gpu_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpu_consts.svh"

module gpu_top
    import gpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   launch,
    input  color_t kernel_mul,
    input  color_t kernel_add,
    output logic   busy,
    output logic   frame_done,
    output color_t pixel,
    output logic   blank_n,
    output logic   h_sync,
    output logic   v_sync
);

    core_mask_t core_start;
    core_mask_t core_ready;
    core_mask_t mem_req;
    core_mask_t mem_ack;
    pix_addr_t  tile_base;
    color_t     mul;
    color_t     add;
    logic       scan_start;
    logic       scan_done;
    pix_addr_t  rd_addr;
    color_t     rd_data;

    logic [`NUM_CORES*`PIX_W-1:0]   wr_addr;  // core i owns slice i.
    logic [`NUM_CORES*`COLOR_W-1:0] wr_data;

    task_scheduler i_sched (
        .clk        (clk),
        .rst        (rst),
        .launch     (launch),
        .kernel_mul (kernel_mul),
        .kernel_add (kernel_add),
        .core_ready (core_ready),
        .scan_done  (scan_done),
        .core_start (core_start),
        .tile_base  (tile_base),
        .mul        (mul),
        .add        (add),
        .scan_start (scan_start),
        .frame_done (frame_done),
        .busy       (busy)
    );

    for (genvar i = 0; i < `NUM_CORES; i++) begin : g_core
        shader_core i_core (
            .clk       (clk),
            .rst       (rst),
            .start     (core_start[i]),
            .tile_base (tile_base),
            .mul       (mul),
            .add       (add),
            .mem_ack   (mem_ack[i]),
            .ready     (core_ready[i]),
            .mem_req   (mem_req[i]),
            .mem_addr  (wr_addr[i*`PIX_W +: `PIX_W]),
            .mem_data  (wr_data[i*`COLOR_W +: `COLOR_W])
        );
    end

    shared_mem i_mem (
        .clk     (clk),
        .rst     (rst),
        .req     (mem_req),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .ack     (mem_ack),
        .rd_data (rd_data)
    );

    scanout i_scan (
        .clk     (clk),
        .rst     (rst),
        .start   (scan_start),
        .rd_data (rd_data),
        .rd_addr (rd_addr),
        .pixel   (pixel),
        .blank_n (blank_n),
        .h_sync  (h_sync),
        .v_sync  (v_sync),
        .done    (scan_done)
    );

endmodule

`default_nettype wire

//--- test/gpu_props.sv
`timescale 1ns/1ns
`default_nettype none

// The write arbiter and the tile dispatcher follow the same grant rules.
module gpu_props
    import gpu_pkg::*;
#(
    parameter bit CHECK_PULSE = 1'b1  // only the dispatcher drives a single-cycle pulse.
)(
    input logic       clk,
    input logic       rst,
    input core_mask_t eligible,
    input core_mask_t grant,
    input logic       pulse
);

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("more than one grant in one cycle");

    a_grant_eligible: assert property (@(posedge clk) disable iff (rst)
        (grant & ~eligible) == '0)
        else $error("grant to a core that is not eligible");

    if (CHECK_PULSE) begin : g_pulse
        a_pulse_single: assert property (@(posedge clk) disable iff (rst) pulse |=> !pulse)
            else $error("pulse longer than one cycle");
    end

endmodule

bind shared_mem gpu_props #(.CHECK_PULSE(1'b0)) i_mem_props (
    .clk(clk), .rst(rst), .eligible(req), .grant(ack), .pulse(1'b0)
);

bind task_scheduler gpu_props i_sched_props (
    .clk(clk), .rst(rst), .eligible(core_ready), .grant(core_start), .pulse(frame_done)
);

`default_nettype wire

//--- test/gpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpu_consts.svh"

module gpu_tb
    import gpu_pkg::*;
();

    localparam int          DRIVE_DELAY    = 10;
    localparam int          RESET_CYCLES   = 8;
    localparam int          RANDOM_KERNELS = 8;
    localparam int          FRAME_CYCLES   = 200;  // compute plus the 50-cycle raster, with slack.
    localparam int          TIMEOUT_CYCLES = (RANDOM_KERNELS + 2) * FRAME_CYCLES
                                           + 4 * RESET_CYCLES;
    localparam logic [31:0] LFSR_SEED      = 32'h2e58582f;

    logic   clk;
    logic   rst;
    logic   launch;
    color_t kernel_mul;
    color_t kernel_add;
    logic   busy;
    logic   frame_done;
    color_t pixel;
    logic   blank_n;
    logic   h_sync;
    logic   v_sync;

    logic [31:0] lfsr_state = LFSR_SEED;
    string       cur_name;
    color_t      cur_mul;
    color_t      cur_add;
    int          errors = 0;
    int          checks_done = 0;
    int          err_before;
    int          chk_before;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    // monitor state, owned by the negedge process.
    logic reset_pending = 1'b0;
    logic busy_q = 1'b0;
    int   pix_idx = 0;
    int   fd_count = 0;
    int   hs_run = 0;
    int   hs_pulses = 0;
    int   vs_run = 0;
    int   vs_pulses = 0;

    gpu_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .launch     (launch),
        .kernel_mul (kernel_mul),
        .kernel_add (kernel_add),
        .busy       (busy),
        .frame_done (frame_done),
        .pixel      (pixel),
        .blank_n    (blank_n),
        .h_sync     (h_sync),
        .v_sync     (v_sync)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, shifting toward the msb.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_byte(output color_t value);
        value = '0;
        for (int b = 0; b < `COLOR_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[`COLOR_W-2:0], lfsr_state[0]};
        end
    endtask

    // color of pixel idx, kept to the low 8 bits of idx * mul + add.
    function automatic color_t expected_color(input int idx, input color_t m, input color_t a);
        int p;
        p = idx * int'(m) + int'(a);
        return color_t'(p % 256);
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error: test %s, %s: expected %0d, actual %0d",
                     cur_name, what, expected, actual);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            reset_pending = 1'b1;
        end else begin
            if (reset_pending) begin
                check_value("busy after reset", 0, int'(busy));
                check_value("frame_done after reset", 0, int'(frame_done));
                check_value("blank_n after reset", 0, int'(blank_n));
                check_value("h_sync after reset", 0, int'(h_sync));
                check_value("v_sync after reset", 0, int'(v_sync));
                reset_pending = 1'b0;
                checks_done++;
            end
            if (busy && !busy_q) begin
                fd_count  = 0;
                pix_idx   = 0;
                hs_pulses = 0;
                vs_pulses = 0;
            end
            if (frame_done) begin
                fd_count++;
            end
            if (blank_n) begin
                check_value($sformatf("pixel %0d", pix_idx),
                            int'(expected_color(pix_idx, cur_mul, cur_add)), int'(pixel));
                pix_idx++;
            end
            if (h_sync) begin
                hs_run++;
            end else if (hs_run != 0) begin
                check_value("h_sync length", `H_BLANK, hs_run);
                hs_pulses++;
                hs_run = 0;
            end
            if (v_sync) begin
                vs_run++;
            end else if (vs_run != 0) begin
                check_value("v_sync length", `V_BLANK, vs_run);
                vs_pulses++;
                vs_run = 0;
            end
            // busy drops in the cycle after the raster ends.
            if (!busy && busy_q) begin
                check_value("frame_done pulses", 1, fd_count);
                check_value("active cycles", `FB_PIXELS, pix_idx);
                check_value("h_sync pulses", `FB_LINES, hs_pulses);
                check_value("v_sync pulses", 1, vs_pulses);
                checks_done++;
            end
        end
        busy_q = busy;
    end

    task automatic start_test(input string name);
        cur_name   = name;
        err_before = errors;
        chk_before = checks_done;
    endtask

    task automatic end_test();
        while (checks_done == chk_before) begin
            @(posedge clk);
        end
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: ok", cur_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_name, errors - err_before);
        end
    endtask

    task automatic launch_kernel(input color_t m, input color_t a);
        @(posedge clk);
        #DRIVE_DELAY;
        launch     = 1'b1;
        kernel_mul = m;
        kernel_add = a;
        @(posedge clk);
        #DRIVE_DELAY;
        launch = 1'b0;
    endtask

    task automatic run_kernel(input string name, input color_t m, input color_t a,
                              input logic late_launch);
        start_test(name);
        cur_mul = m;
        cur_add = a;
        launch_kernel(m, a);
        if (late_launch) begin
            repeat (3) @(posedge clk);
            launch_kernel(m ^ 8'ha5, a + 8'd17);  // arrives mid-frame and must be dropped.
        end
        end_test();
    endtask

    initial begin
        color_t m;
        color_t a;
        rst        = 1'b1;
        launch     = 1'b0;
        kernel_mul = '0;
        kernel_add = '0;
        cur_mul    = '0;
        cur_add    = '0;
        start_test("reset");
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        end_test();

        run_kernel("fixed_kernel", 8'd3, 8'd5, 1'b0);
        run_kernel("launch_while_busy", 8'd7, 8'd200, 1'b1);
        for (int k = 0; k < RANDOM_KERNELS; k++) begin
            draw_byte(m);
            draw_byte(a);
            run_kernel($sformatf("random_%0d", k), m, a, 1'b0);
        end

        $display("summary: %0d tests ok, %0d tests with errors, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/gpu_pkg.sv
rtl/task_scheduler.sv
rtl/shader_core.sv
rtl/shared_mem.sv
rtl/scanout.sv
rtl/gpu_top.sv
test/gpu_props.sv
test/gpu_tb.sv

//--- Makefile
TOP := gpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
